//--- source/cpuPkg.sv
package cpuPkg;

	localparam int numRegs = 8;
	localparam int zeroFlag = 3; // alu flags are {zero, negative, carry, overflow}

	typedef logic [15:0] wordT;

	typedef enum logic [3:0] {
		opAdd  = 4'd0,
		opSub  = 4'd1,
		opAnd  = 4'd2,
		opOr   = 4'd3,
		opXor  = 4'd4,
		opShl  = 4'd5,
		opShr  = 4'd6,
		opAddi = 4'd7,
		opLd   = 4'd8,
		opSt   = 4'd9,
		opBeqz = 4'd10,
		opJal  = 4'd11,
		opJr   = 4'd12,
		opPush = 4'd13,
		opPop  = 4'd14,
		opHalt = 4'd15
	} opcodeT;

	// three views of the same instruction word
	typedef struct packed {
		opcodeT     opcode;
		logic [2:0] rd;
		logic [2:0] rs1;
		logic [2:0] rs2;
		logic [2:0] spare;
	} rFmtT;

	typedef struct packed {
		opcodeT     opcode;
		logic [2:0] rd;
		logic [2:0] rs1;
		logic [5:0] imm6;
	} iFmtT;

	typedef struct packed {
		opcodeT     opcode;
		logic [2:0] rd;
		logic [8:0] imm9;
	} jFmtT;

	typedef union packed {
		rFmtT r;
		iFmtT i;
		jFmtT j;
	} instrT;

	// first seven entries line up with the R-type opcodes
	typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluXor, aluShl, aluShr, aluPassA} aluOpT;

	typedef enum logic [1:0] {op1Rs1, op1Pc, op1Sp, op1Rd} op1SelT;
	typedef enum logic [1:0] {op2Rs2, op2Imm6, op2Imm9, op2One} op2SelT;
	typedef enum logic [1:0] {pcPlusOne, pcAlu, pcLr} pcSelT;
	typedef enum logic {wdAlu, wdMem} wdSelT;

	localparam wordT pcInit = 16'h0000;
	localparam wordT spInit = 16'h0100; // stack grows down from here

endpackage

//--- source/alu.sv
`timescale 1ns/1ps

module alu (
	input  cpuPkg::wordT  a,
	input  cpuPkg::wordT  b,
	input  cpuPkg::aluOpT op,
	output cpuPkg::wordT  result,
	output logic [3:0]    flags
);

	logic [16:0] wide; // bit 16 is carry or borrow out
	logic        overflow;

	always_comb begin
		case (op)
			cpuPkg::aluAdd: wide = {1'b0, a} + {1'b0, b};
			cpuPkg::aluSub: wide = {1'b0, a} - {1'b0, b}; // borrow lands in bit 16
			cpuPkg::aluAnd: wide = {1'b0, a & b};
			cpuPkg::aluOr:  wide = {1'b0, a | b};
			cpuPkg::aluXor: wide = {1'b0, a ^ b};
			cpuPkg::aluShl: wide = {1'b0, a} << b[3:0]; // last bit out becomes carry
			cpuPkg::aluShr: wide = {1'b0, a >> b[3:0]};
			default:        wide = {1'b0, a}; // passA
		endcase
	end

	assign result = wide[15:0];

	// signed overflow only means something for add and sub
	always_comb begin
		case (op)
			cpuPkg::aluAdd: overflow = (a[15] == b[15]) && (result[15] != a[15]);
			cpuPkg::aluSub: overflow = (a[15] != b[15]) && (result[15] != a[15]);
			default:        overflow = 1'b0;
		endcase
	end

	assign flags = {result == '0, result[15], wide[16], overflow};

endmodule

//--- source/regBlock.sv
`timescale 1ns/1ps

module regBlock (
	input  logic         Clock,
	input  logic         rstN,
	input  logic [2:0]   rs1,
	input  logic [2:0]   rs2,
	input  logic [2:0]   rd,
	output cpuPkg::wordT rd1,
	output cpuPkg::wordT rd2,
	output cpuPkg::wordT rdData,
	input  logic         we,
	input  cpuPkg::wordT wData
);

	cpuPkg::wordT regs [cpuPkg::numRegs];

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			for (int i = 0; i < cpuPkg::numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[rd] <= wData; // rd is the only write target
		end
	end

	assign rd1    = regs[rs1];
	assign rd2    = regs[rs2];
	assign rdData = regs[rd]; // store data and branch test

	// an X on the write enable would corrupt a register silently
	aWeKnown: assert property (@(posedge Clock) disable iff (!rstN) !$isunknown(we))
		else $error("regBlock write enable is unknown");

endmodule

//--- source/specialReg.sv
`timescale 1ns/1ps

module specialReg #(
	parameter type  dataT    = cpuPkg::wordT,
	parameter dataT resetVal = '0
) (
	input  logic Clock,
	input  logic rstN,
	input  logic we,
	input  dataT d,
	output dataT q
);

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			q <= resetVal;
		end else if (we) begin
			q <= d; // otherwise hold
		end
	end

endmodule

//--- source/datapath.sv
`timescale 1ns/1ps

module datapath (
	input  logic            Clock,
	input  logic            rstN,
	input  cpuPkg::aluOpT   aluOp,
	input  cpuPkg::op1SelT  op1Sel,
	input  cpuPkg::op2SelT  op2Sel,
	input  cpuPkg::pcSelT   pcSel,
	input  cpuPkg::wdSelT   wdSel,
	input  logic            memAddrSel, // 1 selects PC for a fetch
	input  logic            pcWe,
	input  logic            spWe,
	input  logic            spDec,
	input  logic            lrWe,
	input  logic            irWe,
	input  logic            aluOutWe,
	input  logic            regWe,
	output cpuPkg::opcodeT  opcode,
	output logic            zero,
	output cpuPkg::wordT    memAddr,
	output cpuPkg::wordT    memWData,
	input  cpuPkg::wordT    memRData
);

	cpuPkg::instrT ir;
	cpuPkg::wordT  pc;
	cpuPkg::wordT  sp;
	cpuPkg::wordT  lr;
	cpuPkg::wordT  aluOut;
	cpuPkg::wordT  pcNext;
	cpuPkg::wordT  op1;
	cpuPkg::wordT  op2;
	cpuPkg::wordT  aluResult;
	cpuPkg::wordT  rd1;
	cpuPkg::wordT  rd2;
	cpuPkg::wordT  rdData;
	cpuPkg::wordT  imm6Ext;
	cpuPkg::wordT  imm9Ext;
	cpuPkg::wordT  intBus;
	cpuPkg::aluOpT aluOpEff;
	logic [3:0]    aluFlags;

	assign opcode  = ir.i.opcode;
	assign imm6Ext = {{10{ir.i.imm6[5]}}, ir.i.imm6};
	assign imm9Ext = {{7{ir.j.imm9[8]}}, ir.j.imm9};

	always_comb begin
		case (op1Sel)
			cpuPkg::op1Rs1: op1 = rd1;
			cpuPkg::op1Pc:  op1 = pc;
			cpuPkg::op1Sp:  op1 = sp;
			default:        op1 = rdData; // op1Rd
		endcase
		case (op2Sel)
			cpuPkg::op2Rs2:  op2 = rd2;
			cpuPkg::op2Imm6: op2 = imm6Ext;
			cpuPkg::op2Imm9: op2 = imm9Ext;
			default:         op2 = 16'd1;
		endcase
	end

	// stack updates take their direction from spDec
	assign aluOpEff = spWe ? (spDec ? cpuPkg::aluSub : cpuPkg::aluAdd) : aluOp;

	always_comb begin
		case (pcSel)
			cpuPkg::pcAlu: pcNext = aluOut; // branch or jump target
			cpuPkg::pcLr:  pcNext = lr;
			default:       pcNext = pc + 16'd1;
		endcase
	end

	assign intBus   = (wdSel == cpuPkg::wdMem) ? memRData : aluOut;
	assign memAddr  = memAddrSel ? pc : aluOut;
	assign memWData = rdData;
	assign zero     = aluFlags[cpuPkg::zeroFlag];

	regBlock iRegs (
		.Clock  (Clock),
		.rstN   (rstN),
		.rs1    (ir.i.rs1),
		.rs2    (ir.r.rs2),
		.rd     (ir.i.rd),
		.rd1    (rd1),
		.rd2    (rd2),
		.rdData (rdData),
		.we     (regWe),
		.wData  (intBus)
	);

	alu iAlu (
		.a      (op1),
		.b      (op2),
		.op     (aluOpEff),
		.result (aluResult),
		.flags  (aluFlags)
	);

	specialReg #(.dataT(cpuPkg::wordT), .resetVal(cpuPkg::pcInit)) pcReg (
		.Clock (Clock), .rstN (rstN), .we (pcWe), .d (pcNext), .q (pc)
	);

	specialReg #(.dataT(cpuPkg::wordT), .resetVal(cpuPkg::spInit)) spReg (
		.Clock (Clock), .rstN (rstN), .we (spWe), .d (aluResult), .q (sp)
	);

	// PC already points past the JAL when LR samples it
	specialReg #(.dataT(cpuPkg::wordT)) lrReg (
		.Clock (Clock), .rstN (rstN), .we (lrWe), .d (pc), .q (lr)
	);

	specialReg #(.dataT(cpuPkg::instrT)) irReg (
		.Clock (Clock), .rstN (rstN), .we (irWe), .d (cpuPkg::instrT'(memRData)), .q (ir)
	);

	specialReg #(.dataT(cpuPkg::wordT)) aluOutReg (
		.Clock (Clock), .rstN (rstN), .we (aluOutWe), .d (aluResult), .q (aluOut)
	);

endmodule

//--- source/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
	input  logic            Clock,
	input  logic            rstN,
	input  cpuPkg::opcodeT  opcode,
	input  logic            zero,
	input  logic            memReady,
	output cpuPkg::aluOpT   aluOp,
	output cpuPkg::op1SelT  op1Sel,
	output cpuPkg::op2SelT  op2Sel,
	output cpuPkg::pcSelT   pcSel,
	output cpuPkg::wdSelT   wdSel,
	output logic            memAddrSel,
	output logic            pcWe,
	output logic            spWe,
	output logic            spDec,
	output logic            lrWe,
	output logic            irWe,
	output logic            aluOutWe,
	output logic            regWe,
	output logic            memValid,
	output logic            memWrite,
	output logic            halted
);

	typedef enum logic [2:0] {sIdle, sFetch, sDecode, sExec, sMem, sWb, sHalted} stateT;

	stateT state;
	stateT nextState;

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			state <= sIdle;
		end else begin
			state <= nextState;
		end
	end

	assign halted = (state == sHalted);

	always_comb begin
		nextState  = state;
		aluOp      = cpuPkg::aluAdd;
		op1Sel     = cpuPkg::op1Rs1;
		op2Sel     = cpuPkg::op2Rs2;
		pcSel      = cpuPkg::pcPlusOne;
		wdSel      = cpuPkg::wdAlu;
		memAddrSel = 1'b0;
		pcWe       = 1'b0;
		spWe       = 1'b0;
		spDec      = 1'b0;
		lrWe       = 1'b0;
		irWe       = 1'b0;
		aluOutWe   = 1'b0;
		regWe      = 1'b0;
		memValid   = 1'b0;
		memWrite   = 1'b0;
		case (state)
			sIdle: nextState = sFetch;
			sFetch: begin
				memValid   = 1'b1;
				memAddrSel = 1'b1;
				if (memReady) begin // IR and PC+1 on the transfer edge
					irWe      = 1'b1;
					pcWe      = 1'b1;
					nextState = sDecode;
				end
			end
			sDecode: nextState = (opcode == cpuPkg::opHalt) ? sHalted : sExec;
			sExec: begin
				nextState = sWb;
				aluOutWe  = 1'b1;
				case (opcode)
					cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd, cpuPkg::opOr,
					cpuPkg::opXor, cpuPkg::opShl, cpuPkg::opShr:
						aluOp = cpuPkg::aluOpT'(opcode[2:0]);
					cpuPkg::opAddi: op2Sel = cpuPkg::op2Imm6;
					cpuPkg::opLd, cpuPkg::opSt: begin
						op2Sel    = cpuPkg::op2Imm6; // rs1 + imm6
						nextState = sMem;
					end
					cpuPkg::opBeqz: begin
						op1Sel = cpuPkg::op1Pc;
						op2Sel = cpuPkg::op2Imm6;
					end
					cpuPkg::opJal: begin
						op1Sel = cpuPkg::op1Pc;
						op2Sel = cpuPkg::op2Imm9;
						lrWe   = 1'b1;
					end
					cpuPkg::opJr: begin
						aluOutWe = 1'b0;
						pcSel    = cpuPkg::pcLr;
						pcWe     = 1'b1;
					end
					cpuPkg::opPush: begin
						op1Sel    = cpuPkg::op1Sp; // new SP is also the store address
						op2Sel    = cpuPkg::op2One;
						spWe      = 1'b1;
						spDec     = 1'b1;
						nextState = sMem;
					end
					cpuPkg::opPop: begin
						op1Sel    = cpuPkg::op1Sp;
						aluOp     = cpuPkg::aluPassA; // old SP as address
						nextState = sMem;
					end
					default: aluOutWe = 1'b0;
				endcase
			end
			sMem: begin
				memValid = 1'b1;
				memWrite = (opcode == cpuPkg::opSt) || (opcode == cpuPkg::opPush);
				wdSel    = cpuPkg::wdMem;
				op1Sel   = cpuPkg::op1Sp; // ALU is free, used for the POP increment
				op2Sel   = cpuPkg::op2One;
				if (memReady) begin
					regWe     = (opcode == cpuPkg::opLd) || (opcode == cpuPkg::opPop);
					spWe      = (opcode == cpuPkg::opPop);
					nextState = sFetch;
				end
			end
			sWb: begin
				nextState = sFetch;
				case (opcode)
					cpuPkg::opBeqz: begin
						op1Sel = cpuPkg::op1Rd;
						aluOp  = cpuPkg::aluPassA;
						pcSel  = cpuPkg::pcAlu;
						pcWe   = zero; // taken when rd is zero
					end
					cpuPkg::opJal: begin
						pcSel = cpuPkg::pcAlu;
						pcWe  = 1'b1;
					end
					default: regWe = (opcode <= cpuPkg::opAddi); // ALU and ADDI results
				endcase
			end
			default: nextState = sHalted; // stays here until reset
		endcase
	end

	// request must not change while memory stalls
	aReqHold: assert property (@(posedge Clock) disable iff (!rstN)
		memValid && !memReady |=> memValid && $stable(memWrite) && $stable(memAddrSel))
		else $error("memory request changed during a wait");

	aHaltQuiet: assert property (@(posedge Clock) disable iff (!rstN)
		halted |=> halted && !memValid)
		else $error("bus activity after halt");

	// a fetched word with X bits would send decode astray
	aOpcodeKnown: assert property (@(posedge Clock) disable iff (!rstN)
		state == sDecode |-> !$isunknown(opcode))
		else $error("unknown opcode in decode");

endmodule

//--- source/cpuTop.sv
`timescale 1ns/1ps

module cpuTop (
	input  logic         Clock,
	input  logic         rstN,
	output logic         memValid,
	output logic         memWrite,
	output cpuPkg::wordT memAddr,
	output cpuPkg::wordT memWData,
	input  logic         memReady,
	input  cpuPkg::wordT memRData,
	output logic         halted
);

	cpuPkg::opcodeT opcode;
	logic           zero;
	cpuPkg::aluOpT  aluOp;
	cpuPkg::op1SelT op1Sel;
	cpuPkg::op2SelT op2Sel;
	cpuPkg::pcSelT  pcSel;
	cpuPkg::wdSelT  wdSel;
	logic           memAddrSel;
	logic           pcWe;
	logic           spWe;
	logic           spDec;
	logic           lrWe;
	logic           irWe;
	logic           aluOutWe;
	logic           regWe;

	// port names match the wires one to one
	controlUnit iControl (.*);

	datapath iDatapath (.*);

endmodule

//--- dv/cpuTb.sv
`timescale 1ns/1ps

module cpuTb;

	logic         Clock;
	logic         rstN;
	logic         memValid;
	logic         memWrite;
	cpuPkg::wordT memAddr;
	cpuPkg::wordT memWData;
	logic         memReady;
	cpuPkg::wordT memRData;
	logic         halted;

	cpuPkg::wordT mem [256];    // memory seen by the DUT
	cpuPkg::wordT refMem [256]; // same image, run by the reference model
	cpuPkg::wordT prog [$];
	integer       seed = 32'h4e86_1fe7;
	int           errors = 0;

	cpuTop i_dut (.*);

	initial begin
		Clock = 1'b0;
		forever #50 Clock = ~Clock;
	end

	function automatic cpuPkg::wordT encode(logic [3:0] op, int rd, int rs1, int low6);
		return {op, rd[2:0], rs1[2:0], low6[5:0]}; // R-type passes rs2 * 8 as low6
	endfunction

	// instruction-set model, returns the number of steps up to HALT or -1
	function automatic int runReference();
		cpuPkg::wordT r [8];
		cpuPkg::wordT pc;
		cpuPkg::wordT sp;
		cpuPkg::wordT lr;
		cpuPkg::wordT ins;
		cpuPkg::wordT a;
		cpuPkg::wordT b;
		cpuPkg::wordT imm6;
		cpuPkg::wordT addr;
		logic [2:0]   rd;
		r  = '{default: '0};
		pc = cpuPkg::pcInit;
		sp = cpuPkg::spInit;
		lr = '0;
		for (int step = 1; step <= 5000; step++) begin
			ins  = refMem[pc[7:0]];
			pc   = pc + 16'd1; // branch offsets count from the next word
			rd   = ins[11:9];
			a    = r[ins[8:6]];
			b    = r[ins[5:3]];
			imm6 = {{10{ins[5]}}, ins[5:0]};
			addr = a + imm6;
			case (ins[15:12])
				cpuPkg::opAdd:  r[rd] = a + b;
				cpuPkg::opSub:  r[rd] = a - b;
				cpuPkg::opAnd:  r[rd] = a & b;
				cpuPkg::opOr:   r[rd] = a | b;
				cpuPkg::opXor:  r[rd] = a ^ b;
				cpuPkg::opShl:  r[rd] = a << b[3:0];
				cpuPkg::opShr:  r[rd] = a >> b[3:0];
				cpuPkg::opAddi: r[rd] = addr;
				cpuPkg::opLd:   r[rd] = refMem[addr[7:0]];
				cpuPkg::opSt:   refMem[addr[7:0]] = r[rd];
				cpuPkg::opBeqz: begin
					if (r[rd] == '0) begin
						pc = pc + imm6;
					end
				end
				cpuPkg::opJal: begin
					lr = pc;
					pc = pc + {{7{ins[8]}}, ins[8:0]};
				end
				cpuPkg::opJr:   pc = lr;
				cpuPkg::opPush: begin
					sp = sp - 16'd1;
					refMem[sp[7:0]] = r[rd];
				end
				cpuPkg::opPop: begin
					r[rd] = refMem[sp[7:0]];
					sp    = sp + 16'd1;
				end
				default: return step; // HALT
			endcase
		end
		return -1;
	endfunction

	// memory model, ready only for a request already held over the last edge
	always @(posedge Clock) begin
		int           rnd;
		logic         waiting;
		logic         heldWrite;
		cpuPkg::wordT heldAddr;
		cpuPkg::wordT heldData;
		if (!rstN) begin
			memReady <= 1'b0;
			waiting = 1'b0;
		end else begin
			rnd = $random(seed);
			if (waiting) begin
				assert (memValid === 1'b1 && memAddr === heldAddr && memWrite === heldWrite
					&& memWData === heldData) else begin
					errors++;
					$display("Fail request in wait: memValid %h memAddr %h/%h",
						memValid, memAddr, heldAddr);
					$display("Fail request in wait: memWrite %h/%h memWData %h/%h",
						memWrite, heldWrite, memWData, heldData);
				end
			end
			if (memValid && memReady && memWrite) begin
				mem[memAddr[7:0]] = memWData; // upper address bits ignored
			end
			waiting   = memValid && !memReady;
			heldAddr  = memAddr;
			heldWrite = memWrite;
			heldData  = memWData;
			memRData <= mem[memAddr[7:0]];
			memReady <= waiting && rnd[1:0] != 2'b00;
		end
	end

	task automatic holdReset();
		rstN <= 1'b0;
		@(posedge Clock);
		prog.delete();
	endtask

	task automatic setDataBase();
		prog.push_back(encode(cpuPkg::opAddi, 7, 0, 31));
		prog.push_back(encode(cpuPkg::opAddi, 7, 7, 31));
		prog.push_back(encode(cpuPkg::opAddi, 7, 7, 2)); // r7 = 16'h0040
	endtask

	task automatic addRandomBody(int len);
		int v;
		int kind;
		int rd;
		int depth;
		depth = 0;
		for (int i = 0; i < len; i++) begin
			v    = $random(seed);
			kind = v & 15;
			rd   = 1 + ((v >> 4) & 7) % 6; // r7 keeps the data base
			if (kind < 7) begin
				prog.push_back(encode(4'(kind), rd, (v >> 7) & 7, ((v >> 10) & 7) * 8));
			end else if (kind < 10) begin
				prog.push_back(encode(cpuPkg::opAddi, rd, (v >> 7) & 7, v >> 10));
			end else if (kind < 12) begin
				prog.push_back(encode(cpuPkg::opLd, rd, 7, (v >> 10) & 31));
			end else if (kind < 14) begin
				prog.push_back(encode(cpuPkg::opSt, rd, 7, (v >> 10) & 31));
			end else if (kind == 15 && depth > 0) begin
				prog.push_back(encode(cpuPkg::opPop, rd, 0, 0));
				depth--;
			end else begin
				prog.push_back(encode(cpuPkg::opPush, rd, 0, 0));
				depth++;
			end
		end
		prog.push_back(encode(cpuPkg::opHalt, 0, 0, 0));
	endtask

	task automatic runProgram(string name);
		int cycles;
		for (int a = 0; a < 256; a++) begin
			mem[a]    = {a[7:0], ~a[7:0]}; // fill word tells every address apart
			refMem[a] = mem[a];
		end
		foreach (prog[i]) begin
			mem[i]    = prog[i];
			refMem[i] = prog[i];
		end
		repeat (9) @(posedge Clock);
		rstN <= 1'b1;
		@(posedge Clock);
		assert (memValid === 1'b0 && halted === 1'b0) else begin
			errors++;
			$display("Fail after reset: memValid %h halted %h (%s)", memValid, halted, name);
		end
		cycles = 0;
		while (halted !== 1'b1 && cycles < 20000) begin
			@(posedge Clock);
			cycles++;
		end
		if (halted !== 1'b1) begin
			errors++;
			$display("Program %s hung: halted never rose within %0d cycles", name, cycles);
		end
		if (runReference() < 0) begin
			errors++;
			$display("Reference model never reached HALT in program %s", name);
		end
		for (int a = 0; a < 256; a++) begin
			assert (mem[a] === refMem[a]) else begin
				errors++;
				$display("Fail mem[%h] expected %h actual %h (%s)", a[7:0], refMem[a], mem[a], name);
			end
		end
		repeat (50) begin
			@(posedge Clock);
			assert (halted === 1'b1 && memValid === 1'b0) else begin
				errors++;
				$display("Fail after HALT: halted %h memValid %h (%s)", halted, memValid, name);
			end
		end
	endtask

	initial begin
		rstN     = 1'b0;
		memReady = 1'b0;
		memRData = '0;

		holdReset();
		setDataBase();
		prog.push_back(encode(cpuPkg::opAddi, 1, 0, 21));
		prog.push_back(encode(cpuPkg::opAddi, 2, 0, -7));
		prog.push_back(encode(cpuPkg::opAddi, 3, 0, 3));
		for (int k = 0; k < 7; k++) begin
			prog.push_back(encode(4'(k), 4, k < 5 ? 1 : 2, k < 5 ? 16 : 24)); // shifts r2 by r3
			prog.push_back(encode(cpuPkg::opSt, 4, 7, k));
		end
		prog.push_back(encode(cpuPkg::opHalt, 0, 0, 0));
		runProgram("alu");

		holdReset();
		setDataBase();
		prog.push_back(encode(cpuPkg::opAddi, 1, 0, -32));
		prog.push_back(encode(cpuPkg::opAddi, 1, 1, 31));
		prog.push_back(encode(cpuPkg::opSt, 1, 7, 5));
		prog.push_back(encode(cpuPkg::opAddi, 2, 7, 10)); // computed address
		prog.push_back(encode(cpuPkg::opAddi, 3, 0, 17));
		prog.push_back(encode(cpuPkg::opSt, 3, 2, -3));
		prog.push_back(encode(cpuPkg::opLd, 4, 2, -3));
		prog.push_back(encode(cpuPkg::opAddi, 4, 4, -20));
		prog.push_back(encode(cpuPkg::opSt, 4, 7, 0));
		prog.push_back(encode(cpuPkg::opLd, 5, 7, 20)); // untouched fill word
		prog.push_back(encode(cpuPkg::opSt, 5, 2, 4));
		prog.push_back(encode(cpuPkg::opHalt, 0, 0, 0));
		runProgram("load store");

		holdReset();
		setDataBase();
		prog.push_back(encode(cpuPkg::opAddi, 1, 0, 5)); // loop counter at word 3
		prog.push_back(encode(cpuPkg::opBeqz, 1, 0, 3));  // word 4 exits to 8
		prog.push_back(encode(cpuPkg::opAddi, 2, 2, 1));
		prog.push_back(encode(cpuPkg::opAddi, 1, 1, -1));
		prog.push_back(encode(cpuPkg::opBeqz, 0, 0, -4)); // word 7 goes back to 4
		prog.push_back(encode(cpuPkg::opSt, 2, 7, 0));
		prog.push_back(encode(cpuPkg::opJal, 0, 0, 3));   // word 9 calls 13
		prog.push_back(encode(cpuPkg::opSt, 4, 7, 1));    // return lands here
		prog.push_back(encode(cpuPkg::opSt, 2, 7, 2));
		prog.push_back(encode(cpuPkg::opHalt, 0, 0, 0));
		prog.push_back(encode(cpuPkg::opAddi, 4, 0, -9)); // subroutine at word 13
		prog.push_back(encode(cpuPkg::opAdd, 2, 2, 16));
		prog.push_back(encode(cpuPkg::opJr, 0, 0, 0));
		runProgram("branch call");

		holdReset();
		setDataBase();
		for (int k = 1; k < 4; k++) begin
			prog.push_back(encode(cpuPkg::opAddi, k, 0, 9 * k - 20));
			prog.push_back(encode(cpuPkg::opPush, k, 0, 0));
		end
		for (int k = 4; k < 7; k++) begin
			prog.push_back(encode(cpuPkg::opPop, k, 0, 0)); // r4 gets the last push
			prog.push_back(encode(cpuPkg::opSt, k, 7, k));
		end
		prog.push_back(encode(cpuPkg::opHalt, 0, 0, 0));
		runProgram("stack");

		for (int n = 0; n < 3; n++) begin
			holdReset();
			setDataBase();
			addRandomBody(24);
			runProgram($sformatf("random %0d", n));
		end

		$display("Run finished with %0d errors", errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

//--- filelist.f
source/cpuPkg.sv
source/alu.sv
source/regBlock.sv
source/specialReg.sv
source/datapath.sv
source/controlUnit.sv
source/cpuTop.sv
dv/cpuTb.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the CPU testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module cpuTb -f filelist.f
./obj_dir/VcpuTb | tee sim.log

if grep -q "Checks failed" sim.log; then
	echo "simulation reported errors, see sim.log"
	exit 1
fi
echo "simulation log is clean"
